// ==== common/mempool_lite_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map and bundles assume 32-bit AXI4-Lite, one beat per access
// Region end addresses are exclusive
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mempool_lite_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4001_0000;
  localparam addr_t L2BaseAddr      = 32'h8000_0000; // End follows from bank geometry
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA001_0000;

  // Byte offsets inside the control region
  localparam addr_t CtrlEocOffset     = 32'h0;
  localparam addr_t CtrlWakeUpOffset  = 32'h4;
  localparam addr_t CtrlScratchOffset = 32'h8;
  localparam int unsigned NumScratchRegs = 4;

  // Tiny boot stub: load the L2 entry point, sleep, then jump there
  localparam int unsigned BootromWords = 8;
  localparam data_t BootromImage [BootromWords] = '{
    32'h0000_0297, // auipc t0, 0
    32'h0182_a303, // lw    t1, 24(t0)
    32'h1050_0073, // wfi
    32'h0003_0067, // jr    t1
    32'h0000_0013,
    32'h0000_0013,
    32'h8000_0000, // Entry point
    32'h0000_0000
  };

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10,
    RespDecErr = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    TgtCtrl,
    TgtL2,
    TgtBootrom
  } mem_target_e;

  typedef struct packed {
    addr_t aw_addr;
    logic  aw_valid;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } axil_req_t;

  typedef struct packed {
    logic      aw_ready;
    logic      w_ready;
    logic      b_valid;
    axi_resp_e b_resp;
    logic      ar_ready;
    logic      r_valid;
    data_t     r_data;
    axi_resp_e r_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t word_addr; // Word offset inside the region
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } mem_rsp_t;

  // Merge the strobed bytes of new_data into old_data
  function automatic data_t apply_strb(data_t old_data, data_t new_data, strb_t strb);
    data_t result;
    result = old_data;
    for (int i = 0; i < StrbWidth; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return result;
  endfunction

endpackage

// ==== l2/l2_bank.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port SRAM, contents undefined after reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module l2_bank
  import mempool_lite_pkg::*;
#(
  parameter int unsigned L2BankNumWords = 256,
  localparam int unsigned RowWidth = L2BankNumWords > 1 ? $clog2(L2BankNumWords) : 1
) (
  input  logic                clk_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [RowWidth-1:0] addr_i,
  input  data_t               wdata_i,
  input  strb_t               strb_i,
  output data_t               rdata_o
);

  data_t mem [L2BankNumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= apply_strb(mem[addr_i], wdata_i, strb_i); // Byte lanes only
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== l2/l2_interleaved_mem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-interleaved banks, fixed one-cycle reply, never errors
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module l2_interleaved_mem
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 256
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int unsigned BankSelWidth = NumL2Banks > 1 ? $clog2(NumL2Banks) : 1;
  localparam int unsigned RowWidth     = L2BankNumWords > 1 ? $clog2(L2BankNumWords) : 1;

  logic [BankSelWidth-1:0] bank_sel, bank_q;
  logic [RowWidth-1:0]     row;
  logic [NumL2Banks-1:0]   bank_req;
  data_t                   bank_rdata [NumL2Banks];
  logic                    rvalid_q;

  // Consecutive words land in consecutive banks
  assign bank_sel = BankSelWidth'(req_i.word_addr % NumL2Banks);
  assign row      = RowWidth'(req_i.word_addr / NumL2Banks);

  for (genvar i = 0; i < NumL2Banks; i++) begin : gen_banks
    assign bank_req[i] = req_i.valid && (bank_sel == BankSelWidth'(i));

    l2_bank #(
      .L2BankNumWords(L2BankNumWords)
    ) i_bank (
      .clk_i  (clk_i        ),
      .req_i  (bank_req[i]  ),
      .we_i   (req_i.we     ),
      .addr_i (row          ),
      .wdata_i(req_i.wdata  ),
      .strb_i (req_i.strb   ),
      .rdata_o(bank_rdata[i])
    );
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      bank_q <= bank_sel; // Remember which bank answers next cycle
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = bank_rdata[bank_q];
  assign rsp_o.err    = 1'b0;

endmodule

// ==== design/bootrom.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-only, zero past the boot image
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bootrom
  import mempool_lite_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = BootromWords > 1 ? $clog2(BootromWords) : 1;

  logic  rvalid_q, err_q;
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      err_q   <= req_i.we; // Flag a stray write
      rdata_q <= (req_i.word_addr < BootromWords) ?
                 BootromImage[req_i.word_addr[IdxWidth-1:0]] : '0;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;

endmodule

// ==== design/ctrl_registers.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EOC, wake-up pulse and scratch words; other offsets error
// wake_up_o is high for one cycle after the write request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ctrl_registers
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumCores = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  mem_req_t            req_i,
  output mem_rsp_t            rsp_o,
  output logic                eoc_valid_o,
  output logic [NumCores-1:0] wake_up_o
);

  localparam addr_t EocWord     = CtrlEocOffset >> 2;
  localparam addr_t WakeUpWord  = CtrlWakeUpOffset >> 2;
  localparam addr_t ScratchWord = CtrlScratchOffset >> 2;
  localparam int unsigned ScratchIdxWidth = NumScratchRegs > 1 ? $clog2(NumScratchRegs) : 1;

  data_t                      eoc_q;
  data_t                      scratch_q [NumScratchRegs];
  logic                       sel_eoc, sel_wake, sel_scratch;
  logic [ScratchIdxWidth-1:0] scratch_idx;
  data_t                      rdata_d;

  always_comb begin
    sel_eoc     = (req_i.word_addr == EocWord);
    sel_wake    = (req_i.word_addr == WakeUpWord);
    sel_scratch = (req_i.word_addr >= ScratchWord) &&
                  (req_i.word_addr < ScratchWord + NumScratchRegs);
    scratch_idx = ScratchIdxWidth'(req_i.word_addr - ScratchWord);
    rdata_d     = '0; // Wake-up reads back as zero
    if (sel_eoc) begin
      rdata_d = eoc_q;
    end else if (sel_scratch) begin
      rdata_d = scratch_q[scratch_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q     <= '0;
      wake_up_o <= '0;
      rsp_o     <= '0;
      for (int i = 0; i < NumScratchRegs; i++) begin
        scratch_q[i] <= '0;
      end
    end else begin
      wake_up_o    <= '0; // Single-cycle pulse
      rsp_o.rvalid <= req_i.valid;
      if (req_i.valid) begin
        rsp_o.rdata <= rdata_d;
        rsp_o.err   <= !(sel_eoc || sel_wake || sel_scratch);
        if (req_i.we) begin
          if (sel_eoc) begin
            eoc_q <= apply_strb(eoc_q, req_i.wdata, req_i.strb);
          end
          if (sel_wake) begin
            wake_up_o <= req_i.wdata[NumCores-1:0];
          end
          if (sel_scratch) begin
            scratch_q[scratch_idx] <= apply_strb(scratch_q[scratch_idx], req_i.wdata,
                                                 req_i.strb);
          end
        end
      end
    end
  end

  assign eoc_valid_o = eoc_q[0];

endmodule

// ==== design/axil_mem_demux.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One outstanding AXI4-Lite access, reads win over writes
// B/R valid from the second edge after accept, fixed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axil_mem_demux
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 256
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output mem_req_t  ctrl_req_o,
  output mem_req_t  l2_req_o,
  output mem_req_t  rom_req_o,
  input  mem_rsp_t  ctrl_rsp_i,
  input  mem_rsp_t  l2_rsp_i,
  input  mem_rsp_t  rom_rsp_i
);

  localparam addr_t L2Size    = addr_t'(NumL2Banks * L2BankNumWords * StrbWidth);
  localparam addr_t L2EndAddr = L2BaseAddr + L2Size;

  typedef enum logic [1:0] {Idle, Access, Wait, Resp} state_e;

  state_e      state_q;
  logic        issue_q, we_q;
  logic        rd_accept, wr_accept, resp_done;
  addr_t       acc_addr;
  logic        hit;
  mem_target_e hit_tgt;
  addr_t       hit_base;
  mem_target_e tgt_q;
  addr_t       word_addr_q;
  data_t       wdata_q, rdata_q;
  strb_t       strb_q;
  axi_resp_e   reject_resp_q, resp_q;
  mem_req_t    out_req;
  mem_rsp_t    sel_rsp;

  // Write needs AW and W together and only when no read is pending
  assign rd_accept = (state_q == Idle) && axil_req_i.ar_valid;
  assign wr_accept = (state_q == Idle) && !axil_req_i.ar_valid &&
                     axil_req_i.aw_valid && axil_req_i.w_valid;
  assign acc_addr  = rd_accept ? axil_req_i.ar_addr : axil_req_i.aw_addr;
  assign resp_done = (state_q == Resp) && (we_q ? axil_req_i.b_ready : axil_req_i.r_ready);

  always_comb begin
    hit      = 1'b1;
    hit_tgt  = TgtCtrl;
    hit_base = CtrlBaseAddr;
    if (acc_addr >= L2BaseAddr && acc_addr < L2EndAddr) begin
      hit_tgt  = TgtL2;
      hit_base = L2BaseAddr;
    end else if (acc_addr >= BootromBaseAddr && acc_addr < BootromEndAddr) begin
      hit_tgt  = TgtBootrom;
      hit_base = BootromBaseAddr;
    end else if (acc_addr < CtrlBaseAddr || acc_addr >= CtrlEndAddr) begin
      hit = 1'b0; // Decode miss
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= Idle;
      issue_q <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      case (state_q)
        Idle: if (rd_accept || wr_accept) begin
          state_q <= Access;
          we_q    <= wr_accept;
          issue_q <= hit && !(wr_accept && hit_tgt == TgtBootrom);
        end
        Access: state_q <= Wait;
        Wait:   state_q <= Resp;
        Resp:   if (resp_done) state_q <= Idle;
        default: state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept || wr_accept) begin
      tgt_q         <= hit_tgt;
      word_addr_q   <= (acc_addr - hit_base) >> 2;
      wdata_q       <= axil_req_i.w_data;
      strb_q        <= axil_req_i.w_strb;
      reject_resp_q <= hit ? RespSlvErr : RespDecErr; // ROM write or miss
    end
    if (state_q == Wait) begin
      rdata_q <= '0;
      resp_q  <= reject_resp_q;
      if (issue_q && sel_rsp.rvalid) begin
        rdata_q <= sel_rsp.rdata;
        resp_q  <= sel_rsp.err ? RespSlvErr : RespOkay;
      end
    end
  end

  always_comb begin
    out_req.valid     = (state_q == Access) && issue_q;
    out_req.we        = we_q;
    out_req.word_addr = word_addr_q;
    out_req.wdata     = wdata_q;
    out_req.strb      = strb_q;
    ctrl_req_o        = out_req;
    l2_req_o          = out_req;
    rom_req_o         = out_req;
    ctrl_req_o.valid  = out_req.valid && (tgt_q == TgtCtrl);
    l2_req_o.valid    = out_req.valid && (tgt_q == TgtL2);
    rom_req_o.valid   = out_req.valid && (tgt_q == TgtBootrom);
  end

  always_comb begin
    case (tgt_q)
      TgtL2:      sel_rsp = l2_rsp_i;
      TgtBootrom: sel_rsp = rom_rsp_i;
      default:    sel_rsp = ctrl_rsp_i;
    endcase
  end

  always_comb begin
    axil_rsp_o.aw_ready = wr_accept;
    axil_rsp_o.w_ready  = wr_accept;
    axil_rsp_o.ar_ready = (state_q == Idle);
    axil_rsp_o.b_valid  = (state_q == Resp) && we_q;
    axil_rsp_o.b_resp   = resp_q;
    axil_rsp_o.r_valid  = (state_q == Resp) && !we_q;
    axil_rsp_o.r_data   = rdata_q;
    axil_rsp_o.r_resp   = resp_q;
  end

endmodule

// ==== design/mempool_lite_system.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single AXI4-Lite host port, one transaction in flight
// L2 size is NumL2Banks * L2BankNumWords words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mempool_lite_system
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 256,
  parameter int unsigned NumCores       = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  axil_req_t           axil_req_i,
  output axil_rsp_t           axil_rsp_o,
  output logic                eoc_valid_o,
  output logic [NumCores-1:0] wake_up_o
);

  mem_req_t ctrl_req, l2_req, rom_req;
  mem_rsp_t ctrl_rsp, l2_rsp, rom_rsp;

  axil_mem_demux #(
    .NumL2Banks    (NumL2Banks    ),
    .L2BankNumWords(L2BankNumWords)
  ) i_axil_mem_demux (
    .clk_i     (clk_i     ),
    .reset_i   (reset_i   ),
    .axil_req_i(axil_req_i),
    .axil_rsp_o(axil_rsp_o),
    .ctrl_req_o(ctrl_req  ),
    .l2_req_o  (l2_req    ),
    .rom_req_o (rom_req   ),
    .ctrl_rsp_i(ctrl_rsp  ),
    .l2_rsp_i  (l2_rsp    ),
    .rom_rsp_i (rom_rsp   )
  );

  l2_interleaved_mem #(
    .NumL2Banks    (NumL2Banks    ),
    .L2BankNumWords(L2BankNumWords)
  ) i_l2_mem (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .req_i  (l2_req ),
    .rsp_o  (l2_rsp )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .req_i  (rom_req),
    .rsp_o  (rom_rsp)
  );

  ctrl_registers #(
    .NumCores(NumCores)
  ) i_ctrl_registers (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .req_i      (ctrl_req   ),
    .rsp_o      (ctrl_rsp   ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule

// ==== tests/mempool_lite_properties.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite port checks, bound to the system top
// Response expected on the third sampled edge after accept
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mempool_lite_properties
  import mempool_lite_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input axil_req_t axil_req_i,
  input axil_rsp_t axil_rsp_o
);

  logic        accept;
  logic        pending;
  int unsigned fail_count = 0;

  assign accept  = (axil_req_i.ar_valid && axil_rsp_o.ar_ready) ||
                   (axil_req_i.aw_valid && axil_rsp_o.aw_ready);
  assign pending = axil_rsp_o.b_valid || axil_rsp_o.r_valid;

  // Valids cleared by a reset edge
  reset_clears_valid: assert property (@(posedge clk_i)
    reset_i |=> !axil_rsp_o.b_valid && !axil_rsp_o.r_valid)
    else begin
      fail_count++;
      $error("response valid while in reset");
    end

  b_held_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    axil_rsp_o.b_valid && !axil_req_i.b_ready |=>
      axil_rsp_o.b_valid && $stable(axil_rsp_o.b_resp))
    else begin
      fail_count++;
      $error("B response changed under back-pressure");
    end

  r_held_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    axil_rsp_o.r_valid && !axil_req_i.r_ready |=>
      axil_rsp_o.r_valid && $stable(axil_rsp_o.r_data) && $stable(axil_rsp_o.r_resp))
    else begin
      fail_count++;
      $error("R response changed under back-pressure");
    end

  no_ready_when_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    pending |-> !axil_rsp_o.aw_ready && !axil_rsp_o.w_ready && !axil_rsp_o.ar_ready)
    else begin
      fail_count++;
      $error("ready raised while a response is pending");
    end

  // Nothing early, then the response on the third edge
  fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |=> !pending ##1 !pending ##1 pending)
    else begin
      fail_count++;
      $error("response not at fixed latency");
    end

endmodule

bind mempool_lite_system mempool_lite_properties i_props (
  .clk_i     (clk_i     ),
  .reset_i   (reset_i   ),
  .axil_req_i(axil_req_i),
  .axil_rsp_o(axil_rsp_o)
);

// ==== tests/tb_mempool_lite.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random AXI4-Lite traffic against a behavioral model
// Uses default top parameters, aligned word accesses only
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mempool_lite
  import mempool_lite_pkg::*;
;

  localparam int unsigned NumCores    = 4;
  localparam int unsigned L2Words     = 4 * 256;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned TxBudget    = 400;  // Upper bound on transactions issued
  localparam int unsigned CyclesPerTx = 6;
  localparam int unsigned MaxStall    = 16;
  localparam int unsigned CycleLimit  = ResetCycles + 2 * TxBudget * (CyclesPerTx + MaxStall);

  logic                clk;
  logic                reset_i;
  axil_req_t           req;
  axil_rsp_t           rsp;
  logic                eoc_valid;
  logic [NumCores-1:0] wake_up;

  integer      seed;
  int unsigned cycle_count = 0;
  logic        stall_en;
  int unsigned wake_cycles = 0;
  logic [NumCores-1:0] wake_seen = '0;

  // Model state
  data_t l2_model [L2Words];
  data_t eoc_model;
  data_t scratch_model [NumScratchRegs];
  addr_t written_q [$];

  mempool_lite_system uut (
    .clk_i      (clk      ),
    .reset_i    (reset_i  ),
    .axil_req_i (req      ),
    .axil_rsp_o (rsp      ),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up  )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CycleLimit) begin
      $display("timeout: the run exceeded %0d clock cycles", CycleLimit);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  always @(negedge clk) begin
    if (wake_up != '0) begin
      wake_cycles <= wake_cycles + 1;
      wake_seen   <= wake_up;
    end
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error: time %0t: %s expected %h, got %h", $time, what, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic ready_draw();
    if (!stall_en) return 1'b1;
    return ($random(seed) & 3) != 0; // Ready three times out of four
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic model_read(input addr_t addr, output data_t data, output axi_resp_e resp);
    addr_t off;
    data = '0;
    resp = RespOkay;
    if (addr >= 32'h8000_0000 && addr < 32'h8000_0000 + L2Words * 4) begin
      data = l2_model[(addr - 32'h8000_0000) >> 2];
    end else if (addr >= 32'hA000_0000 && addr < 32'hA001_0000) begin
      off = (addr - 32'hA000_0000) >> 2;
      if (off < 8) data = BootromImage[off];
    end else if (addr >= 32'h4000_0000 && addr < 32'h4001_0000) begin
      off = (addr - 32'h4000_0000) >> 2;
      if (off == 0) data = eoc_model;
      else if (off >= 2 && off < 2 + NumScratchRegs) data = scratch_model[off - 2];
      else if (off != 1) resp = RespSlvErr;
    end else begin
      resp = RespDecErr;
    end
  endtask

  task automatic model_write(input addr_t addr, input data_t data, input strb_t strb,
                             output axi_resp_e resp);
    addr_t off;
    resp = RespOkay;
    if (addr >= 32'h8000_0000 && addr < 32'h8000_0000 + L2Words * 4) begin
      off = (addr - 32'h8000_0000) >> 2;
      l2_model[off] = merge_bytes(l2_model[off], data, strb);
    end else if (addr >= 32'hA000_0000 && addr < 32'hA001_0000) begin
      resp = RespSlvErr; // ROM is read-only
    end else if (addr >= 32'h4000_0000 && addr < 32'h4001_0000) begin
      off = (addr - 32'h4000_0000) >> 2;
      if (off == 0) eoc_model = merge_bytes(eoc_model, data, strb);
      else if (off >= 2 && off < 2 + NumScratchRegs)
        scratch_model[off - 2] = merge_bytes(scratch_model[off - 2], data, strb);
      else if (off != 1) resp = RespSlvErr;
    end else begin
      resp = RespDecErr;
    end
  endtask

  task automatic accept_read();
    logic ok;
    do begin
      @(negedge clk);
      ok = rsp.ar_ready;
      @(posedge clk);
      #2;
    end while (!ok);
    req.ar_valid = 1'b0;
  endtask

  task automatic accept_write();
    logic ok;
    do begin
      @(negedge clk);
      ok = rsp.aw_ready && rsp.w_ready;
      @(posedge clk);
      #2;
    end while (!ok);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
  endtask

  task automatic collect_r(output data_t data, output axi_resp_e resp);
    logic got;
    do begin
      req.r_ready = ready_draw();
      @(negedge clk);
      got = rsp.r_valid && req.r_ready;
      if (got) begin
        data = rsp.r_data;
        resp = rsp.r_resp;
      end
      @(posedge clk);
      #2;
    end while (!got);
    req.r_ready = 1'b0;
  endtask

  task automatic collect_b(output axi_resp_e resp);
    logic got;
    do begin
      req.b_ready = ready_draw();
      @(negedge clk);
      got = rsp.b_valid && req.b_ready;
      if (got) resp = rsp.b_resp;
      @(posedge clk);
      #2;
    end while (!got);
    req.b_ready = 1'b0;
  endtask

  task automatic drive_read(input addr_t addr);
    req.ar_addr  = addr;
    req.ar_valid = 1'b1;
  endtask

  task automatic drive_write(input addr_t addr, input data_t data, input strb_t strb);
    req.aw_addr  = addr;
    req.w_data   = data;
    req.w_strb   = strb;
    req.aw_valid = 1'b1;
    req.w_valid  = 1'b1;
  endtask

  task automatic check_read(input addr_t addr);
    data_t     exp_d, act_d;
    axi_resp_e exp_r, act_r;
    model_read(addr, exp_d, exp_r);
    drive_read(addr);
    accept_read();
    collect_r(act_d, act_r);
    check($sformatf("read resp @%h", addr), exp_r, act_r);
    if (exp_r == RespOkay) check($sformatf("read data @%h", addr), exp_d, act_d);
  endtask

  task automatic check_write(input addr_t addr, input data_t data, input strb_t strb);
    axi_resp_e exp_r, act_r;
    model_write(addr, data, strb, exp_r);
    drive_write(addr, data, strb);
    accept_write();
    collect_b(act_r);
    check($sformatf("write resp @%h", addr), exp_r, act_r);
  endtask

  // Read and write offered together, the read must win
  task automatic read_write_pair(input addr_t raddr, input addr_t waddr,
                                 input data_t wdata, input strb_t wstrb);
    data_t     exp_d, act_d;
    axi_resp_e exp_r, exp_b, act_r, act_b;
    model_read(raddr, exp_d, exp_r);
    model_write(waddr, wdata, wstrb, exp_b);
    drive_read(raddr);
    drive_write(waddr, wdata, wstrb);
    @(negedge clk);
    check("ar_ready with both pending", 1, rsp.ar_ready);
    check("aw_ready with both pending", 0, rsp.aw_ready);
    check("w_ready with both pending", 0, rsp.w_ready);
    @(posedge clk);
    #2;
    req.ar_valid = 1'b0;
    collect_r(act_d, act_r);
    check("pair read resp", exp_r, act_r);
    if (exp_r == RespOkay) check("pair read data", exp_d, act_d);
    accept_write();
    collect_b(act_b);
    check("pair write resp", exp_b, act_b);
  endtask

  initial begin
    addr_t       a;
    int unsigned idx;
    seed        = 32'hb7;
    stall_en    = 1'b0;
    req         = '0;
    reset_i     = 1'b1;
    eoc_model   = '0;
    for (int i = 0; i < NumScratchRegs; i++) scratch_model[i] = '0;
    for (int i = 0; i < L2Words; i++) l2_model[i] = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    reset_i = 1'b0;

    // L2, full word first so every byte is defined, then partial strobes
    for (int i = 0; i < 32; i++) begin
      idx = (($random(seed) & (L2Words - 1)) & ~3) | (i % 4);
      a   = 32'h8000_0000 + idx * 4;
      check_write(a, $random(seed), 4'hf);
      written_q.push_back(a);
    end
    for (int i = 0; i < 32; i++) begin
      a = written_q[$unsigned($random(seed)) % written_q.size()];
      check_write(a, $random(seed), strb_t'($random(seed)));
    end
    foreach (written_q[i]) check_read(written_q[i]);

    // Boot ROM inside and beyond the image
    for (int i = 0; i < 12; i++) check_read(32'hA000_0000 + i * 4);
    check_write(32'hA000_0008, 32'hdead_beef, 4'hf);
    for (int i = 0; i < 8; i++) check_read(32'hA000_0000 + i * 4);

    // Control registers
    for (int i = 0; i < NumScratchRegs; i++) begin
      check_write(32'h4000_0008 + i * 4, $random(seed), 4'hf);
    end
    check_write(32'h4000_000C, $random(seed), strb_t'($random(seed)));
    for (int i = 0; i < NumScratchRegs; i++) check_read(32'h4000_0008 + i * 4);
    check_write(32'h4000_0000, 32'h0000_0001, 4'hf);
    check("eoc_valid_o after set", 1, eoc_valid);
    check_read(32'h4000_0000);
    check_write(32'h4000_0000, 32'h0000_0000, 4'h1);
    check("eoc_valid_o after clear", 0, eoc_valid);
    check_write(32'h4000_0004, 32'h0000_000A, 4'hf);
    check("wake_up_o pulse cycles", 1, wake_cycles);
    check("wake_up_o value", 4'hA, wake_seen);
    check_read(32'h4000_0004);
    check_read(32'h4000_0000);
    for (int i = 0; i < NumScratchRegs; i++) check_read(32'h4000_0008 + i * 4);
    check_read(32'h4000_0018);
    check_write(32'h4000_0100, 32'h1234_5678, 4'hf);

    // Decode errors, L2 word 0 is where the word past the L2 end would wrap
    check_write(32'h8000_0000, 32'h0bad_cafe, 4'hf);
    check_read(32'h0000_0000);
    check_write(32'h1000_0000, 32'hffff_ffff, 4'hf);
    check_read(32'h4001_0000);
    check_write(32'h8000_1000, 32'hffff_ffff, 4'hf);
    check_read(32'hA001_0000);
    check_write(32'hFFFF_FFFC, 32'hffff_ffff, 4'hf);
    check_read(32'h8000_0000 + L2Words * 4 + 32'h100);
    check_read(32'h4000_0008);
    check_read(32'h8000_0000);
    check_read(written_q[0]);

    // Back-pressure with simultaneous read and write
    stall_en = 1'b1;
    for (int i = 0; i < 16; i++) begin
      a = written_q[$unsigned($random(seed)) % written_q.size()];
      if (i % 2 == 0) read_write_pair(a, a, $random(seed), strb_t'($random(seed)));
      else read_write_pair(32'h4000_0008 + (i % 4) * 4, 32'h4000_0008 + (i % 4) * 4,
                           $random(seed), 4'hf);
    end
    foreach (written_q[i]) check_read(written_q[i]);
    for (int i = 0; i < NumScratchRegs; i++) check_read(32'h4000_0008 + i * 4);

    if (uut.i_props.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("%0d concurrent assertions failed", uut.i_props.fail_count);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== mempool_lite.f ====
common/mempool_lite_pkg.sv
l2/l2_bank.sv
l2/l2_interleaved_mem.sv
design/bootrom.sv
design/ctrl_registers.sv
design/axil_mem_demux.sv
design/mempool_lite_system.sv
tests/mempool_lite_properties.sv
tests/tb_mempool_lite.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mempool_lite
FILELIST  = mempool_lite.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
